/* src/bpm_config.svh */
`ifndef BPM_CONFIG_SVH
`define BPM_CONFIG_SVH

////////////////////////////////////////
// Bus and trigger widths
`define BPM_WORD_WIDTH          32
`define BPM_EVENT_TRIG_WIDTH    6

// Event triggers plus the software trigger in bit 0
`define BPM_TRIG_WIDTH          7

////////////////////////////////////////
// Timing generator widths
`define BPM_HEARTBEAT_WIDTH     28
`define BPM_FA_WIDTH            16
`define BPM_SA_WIDTH            24

// Top bit of this counter is the stretched level
`define BPM_SOFT_STRETCH_WIDTH  4

// Heartbeat reload value out of reset
`define BPM_HEARTBEAT_RESET     99

`endif

/* src/bpmPkg.sv */
`include "bpm_config.svh"

package bpmPkg;

    ////////////////////////////////////////
    // Register bus
    typedef logic [`BPM_WORD_WIDTH-1:0] word_t;

    // Unlisted addresses read back as zero
    typedef enum logic [3:0] {
        softTrigger     = 4'd0,
        heartbeatReload = 4'd1,
        faReload        = 4'd2,
        saReload        = 4'd3,
        interlock       = 4'd4,
        spiMux          = 4'd5
    } csrAddr_t;

    // One write strobe per register
    typedef struct packed {
        logic spiMux;
        logic interlock;
        logic saReload;
        logic faReload;
        logic heartbeatReload;
        logic softTrigger;
    } csrStrobes_t;

    ////////////////////////////////////////
    // Triggers and timing payloads
    typedef logic [`BPM_TRIG_WIDTH-1:0]       trigBus_t;
    typedef logic [`BPM_EVENT_TRIG_WIDTH-1:0] eventTrig_t;
    typedef logic [`BPM_FA_WIDTH-1:0]         faReload_t;
    typedef logic [`BPM_SA_WIDTH-1:0]         saReload_t;
    typedef logic [`BPM_HEARTBEAT_WIDTH-1:0]  heartbeatReload_t;

endpackage

/* src/gpioRegisterBank.sv */
`timescale 1ns/1ns

module gpioRegisterBank (
    input  logic                sysClk,
    input  logic                arstN,
    input  bpmPkg::csrAddr_t    csrAddr,
    input  logic                csrWrite,
    input  bpmPkg::word_t       csrWriteData,
    output bpmPkg::word_t       csrReadData,
    output bpmPkg::csrStrobes_t csrStrobes,
    output bpmPkg::word_t       gpioOut,
    input  bpmPkg::word_t       heartbeatStatus,
    input  bpmPkg::word_t       faStatus,
    input  bpmPkg::word_t       saStatus,
    output logic                relayControl,
    output logic [1:0]          clkSpiMuxSel
);

    ////////////////////////////////////////
    // Write capture
    logic             writeQ;
    bpmPkg::csrAddr_t addrQ;
    bpmPkg::word_t    dataQ;

    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            writeQ <= 1'b0;
        end else begin
            writeQ <= csrWrite;
        end
    end

    always_ff @(posedge sysClk) begin
        addrQ <= csrAddr;
        dataQ <= csrWriteData;
    end

    ////////////////////////////////////////
    // Strobe decode, one cycle after capture
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            csrStrobes <= '0;
        end else begin
            csrStrobes.softTrigger     <= writeQ && (addrQ == bpmPkg::softTrigger);
            csrStrobes.heartbeatReload <= writeQ && (addrQ == bpmPkg::heartbeatReload);
            csrStrobes.faReload        <= writeQ && (addrQ == bpmPkg::faReload);
            csrStrobes.saReload        <= writeQ && (addrQ == bpmPkg::saReload);
            csrStrobes.interlock       <= writeQ && (addrQ == bpmPkg::interlock);
            csrStrobes.spiMux          <= writeQ && (addrQ == bpmPkg::spiMux);
        end
    end

    // Word stays aligned with its strobe on back-to-back writes
    always_ff @(posedge sysClk) begin
        gpioOut <= dataQ;
    end

    ////////////////////////////////////////
    // Local control registers
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            relayControl <= 1'b0;
            clkSpiMuxSel <= 2'b00;
        end else begin
            if (csrStrobes.interlock) begin
                relayControl <= gpioOut[0];
            end
            if (csrStrobes.spiMux) begin
                clkSpiMuxSel <= gpioOut[1:0];
            end
        end
    end

    ////////////////////////////////////////
    // Readback mux
    always_comb begin
        case (csrAddr)
            bpmPkg::heartbeatReload: csrReadData = heartbeatStatus;
            bpmPkg::faReload:        csrReadData = faStatus;
            bpmPkg::saReload:        csrReadData = saStatus;
            bpmPkg::interlock:       csrReadData = {31'b0, relayControl};
            bpmPkg::spiMux:          csrReadData = {30'b0, clkSpiMuxSel};
            default:                 csrReadData = '0;
        endcase
    end

endmodule

/* src/triggerConditioner.sv */
`timescale 1ns/1ns
`include "bpm_config.svh"

module triggerConditioner (
    input  logic               sysClk,
    input  logic               arstN,
    input  logic               softTriggerStrobe,
    input  bpmPkg::eventTrig_t eventTriggers,
    output bpmPkg::trigBus_t   triggerStrobes
);

    ////////////////////////////////////////
    // Software trigger stretch
    logic [`BPM_SOFT_STRETCH_WIDTH-1:0] softCount;
    logic                               softTrigger;

    // Level stays high while the count runs down through its upper half
    assign softTrigger = softCount[`BPM_SOFT_STRETCH_WIDTH-1];

    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            softCount <= '0;
        end else if (softTriggerStrobe) begin
            softCount <= '1;
        end else if (softTrigger) begin
            softCount <= softCount - 1'b1;
        end
    end

    ////////////////////////////////////////
    // Synchroniser and edge detect
    bpmPkg::trigBus_t trigMeta;
    bpmPkg::trigBus_t trigSync;
    bpmPkg::trigBus_t trigDelay;

    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            trigMeta       <= '0;
            trigSync       <= '0;
            trigDelay      <= '0;
            triggerStrobes <= '0;
        end else begin
            // Bit 0 carries the stretched software trigger
            trigMeta       <= {eventTriggers, softTrigger};
            trigSync       <= trigMeta;
            trigDelay      <= trigSync;
            triggerStrobes <= trigSync & ~trigDelay;
        end
    end

endmodule

/* src/heartbeatGenerator.sv */
`timescale 1ns/1ns
`include "bpm_config.svh"

module heartbeatGenerator (
    input  logic          sysClk,
    input  logic          arstN,
    input  logic          reloadStrobe,
    input  bpmPkg::word_t gpioOut,
    output logic          adcHeartbeat,
    output bpmPkg::word_t heartbeatStatus
);

    localparam int RELOAD_WIDTH = $bits(bpmPkg::heartbeatReload_t);
    localparam int PAD_WIDTH    = $bits(bpmPkg::word_t) - RELOAD_WIDTH;

    localparam bpmPkg::heartbeatReload_t RESET_RELOAD = `BPM_HEARTBEAT_RESET;

    bpmPkg::heartbeatReload_t reloadReg;
    logic [RELOAD_WIDTH:0]    counter;

    ////////////////////////////////////////
    // Period register
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            reloadReg <= RESET_RELOAD;
        end else if (reloadStrobe) begin
            reloadReg <= gpioOut[RELOAD_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // Down-counter, wraps into its top bit
    // Period is reload + 2 since the wrap cycle counts too
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            counter <= {1'b0, RESET_RELOAD};
        end else if (counter[RELOAD_WIDTH]) begin
            counter <= {1'b0, reloadReg};
        end else begin
            counter <= counter - 1'b1;
        end
    end

    assign adcHeartbeat    = counter[RELOAD_WIDTH];
    assign heartbeatStatus = {{PAD_WIDTH{1'b0}}, reloadReg};

endmodule

/* src/markerDivider.sv */
`timescale 1ns/1ns

module markerDivider #(
    parameter type reload_t = bpmPkg::faReload_t
) (
    input  logic          sysClk,
    input  logic          arstN,
    input  logic          reloadStrobe,
    input  bpmPkg::word_t gpioOut,
    input  logic          heartbeat,
    output logic          marker,
    output bpmPkg::word_t status
);

    localparam int RELOAD_WIDTH = $bits(reload_t);
    localparam int PAD_WIDTH    = $bits(bpmPkg::word_t) - RELOAD_WIDTH - 1;

    reload_t reloadReg;
    reload_t count;
    logic    synced;

    ////////////////////////////////////////
    // Divisor register
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            reloadReg <= '1;
        end else if (reloadStrobe) begin
            reloadReg <= gpioOut[RELOAD_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////
    // Marker count, restarted by every heartbeat
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            count  <= '1;
            marker <= 1'b0;
            synced <= 1'b0;
        end else if (heartbeat) begin
            count  <= reloadReg;
            marker <= 1'b1;
            // In sync only if the divisor would have wrapped here anyway
            synced <= (count == '0);
        end else if (count == '0) begin
            count  <= reloadReg;
            marker <= 1'b1;
        end else begin
            count  <= count - 1'b1;
            marker <= 1'b0;
        end
    end

    assign status = {synced, {PAD_WIDTH{1'b0}}, reloadReg};

endmodule

/* src/bpmTimingTop.sv */
`timescale 1ns/1ns

module bpmTimingTop (
    input  logic               sysClk,
    input  logic               arstN,
    input  bpmPkg::csrAddr_t   csrAddr,
    input  logic               csrWrite,
    input  bpmPkg::word_t      csrWriteData,
    output bpmPkg::word_t      csrReadData,
    input  bpmPkg::eventTrig_t eventTriggers,
    output bpmPkg::trigBus_t   triggerStrobes,
    output logic               adcHeartbeat,
    output logic               faMarker,
    output logic               saMarker,
    output logic               relayControl,
    output logic [1:0]         clkSpiMuxSel
);

    bpmPkg::csrStrobes_t csrStrobes;
    bpmPkg::word_t       gpioOut;
    bpmPkg::word_t       heartbeatStatus;
    bpmPkg::word_t       faStatus;
    bpmPkg::word_t       saStatus;

    ////////////////////////////////////////
    // Register access
    gpioRegisterBank gpioRegisterBank_i (
        .sysClk(sysClk),
        .arstN(arstN),
        .csrAddr(csrAddr),
        .csrWrite(csrWrite),
        .csrWriteData(csrWriteData),
        .csrReadData(csrReadData),
        .csrStrobes(csrStrobes),
        .gpioOut(gpioOut),
        .heartbeatStatus(heartbeatStatus),
        .faStatus(faStatus),
        .saStatus(saStatus),
        .relayControl(relayControl),
        .clkSpiMuxSel(clkSpiMuxSel)
    );

    ////////////////////////////////////////
    // Triggers
    triggerConditioner triggerConditioner_i (
        .sysClk(sysClk),
        .arstN(arstN),
        .softTriggerStrobe(csrStrobes.softTrigger),
        .eventTriggers(eventTriggers),
        .triggerStrobes(triggerStrobes)
    );

    ////////////////////////////////////////
    // Heartbeat and acquisition markers
    heartbeatGenerator heartbeatGenerator_i (
        .sysClk(sysClk),
        .arstN(arstN),
        .reloadStrobe(csrStrobes.heartbeatReload),
        .gpioOut(gpioOut),
        .adcHeartbeat(adcHeartbeat),
        .heartbeatStatus(heartbeatStatus)
    );

    markerDivider #(.reload_t(bpmPkg::faReload_t)) faDivider (
        .sysClk(sysClk),
        .arstN(arstN),
        .reloadStrobe(csrStrobes.faReload),
        .gpioOut(gpioOut),
        .heartbeat(adcHeartbeat),
        .marker(faMarker),
        .status(faStatus)
    );

    markerDivider #(.reload_t(bpmPkg::saReload_t)) saDivider (
        .sysClk(sysClk),
        .arstN(arstN),
        .reloadStrobe(csrStrobes.saReload),
        .gpioOut(gpioOut),
        .heartbeat(adcHeartbeat),
        .marker(saMarker),
        .status(saStatus)
    );

endmodule

/* verification/bpmTiming_props.sv */
`timescale 1ns/1ns

module bpmTimingProps #(
    parameter bit CHECK_STROBES = 1'b0
) (
    input logic             sysClk,
    input logic             arstN,
    input bpmPkg::trigBus_t strobes,
    input logic             heartbeat,
    input logic             marker
);

    int failCount = 0;

    if (CHECK_STROBES) begin : strobeChecks

        ////////////////////////////////////////
        // Trigger strobes
        strobeSingleCycle: assert property (
            @(posedge sysClk) disable iff (!arstN)
            (strobes & $past(strobes)) == '0
        ) else begin
            failCount++;
            $error("triggerStrobes bit high on two cycles running");
        end

    end else begin : markerChecks

        ////////////////////////////////////////
        // Acquisition markers
        markerAfterHeartbeat: assert property (
            @(posedge sysClk) disable iff (!arstN)
            heartbeat |=> marker
        ) else begin
            failCount++;
            $error("marker missing on the cycle after a heartbeat");
        end

        markerQuietInReset: assert property (
            @(posedge sysClk) !arstN |-> !marker
        ) else begin
            failCount++;
            $error("marker pulsed while in reset");
        end

    end

endmodule

bind triggerConditioner bpmTimingProps #(.CHECK_STROBES(1'b1)) trigProps_i (
    .sysClk(sysClk),
    .arstN(arstN),
    .strobes(triggerStrobes),
    .heartbeat(1'b0),
    .marker(1'b0)
);

bind markerDivider bpmTimingProps #(.CHECK_STROBES(1'b0)) markerProps_i (
    .sysClk(sysClk),
    .arstN(arstN),
    .strobes('0),
    .heartbeat(heartbeat),
    .marker(marker)
);

/* verification/bpmTimingTb.sv */
`timescale 1ns/1ns

module bpmTimingTb;

    localparam int CMD_WORDS     = 128;
    localparam int WAIT_LIMIT    = 2000;
    localparam int SOFT_LATENCY  = 6;
    localparam int SOFT_WINDOW   = 30;
    // Two synchroniser flops then the registered edge detect
    localparam int EVENT_LATENCY = 3;
    localparam int EVENT_HOLD    = 5;

    logic               sysClk = 1'b0;
    logic               arstN;
    bpmPkg::csrAddr_t   csrAddr;
    logic               csrWrite;
    bpmPkg::word_t      csrWriteData;
    bpmPkg::word_t      csrReadData;
    bpmPkg::eventTrig_t eventTriggers;
    bpmPkg::trigBus_t   triggerStrobes;
    logic               adcHeartbeat;
    logic               faMarker;
    logic               saMarker;
    logic               relayControl;
    logic [1:0]         clkSpiMuxSel;

    bpmPkg::word_t cmdMem [0:CMD_WORDS-1];
    logic [31:0]   lfsr = 32'h41c59898;

    bpmTimingTop dut_i (
        .sysClk(sysClk),
        .arstN(arstN),
        .csrAddr(csrAddr),
        .csrWrite(csrWrite),
        .csrWriteData(csrWriteData),
        .csrReadData(csrReadData),
        .eventTriggers(eventTriggers),
        .triggerStrobes(triggerStrobes),
        .adcHeartbeat(adcHeartbeat),
        .faMarker(faMarker),
        .saMarker(saMarker),
        .relayControl(relayControl),
        .clkSpiMuxSel(clkSpiMuxSel)
    );

    always #50 sysClk = ~sysClk;

    ////////////////////////////////////////
    // Failure and compare tasks
    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input bpmPkg::word_t actual,
                             input bpmPkg::word_t expected);
        if (actual !== expected) begin
            failRun($sformatf("Error %s actual 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkTrig(input string name, input bpmPkg::trigBus_t actual,
                             input bpmPkg::trigBus_t expected);
        if (actual !== expected) begin
            failRun($sformatf("Error %s actual 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic checkPeriod(input string name, input int actual, input int expected);
        if (actual != expected) begin
            failRun($sformatf("Error %s actual 0x%h expected 0x%h", name, actual, expected));
        end
    endtask

    ////////////////////////////////////////
    // Random event patterns
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end else begin
            return state >> 1;
        end
    endfunction

    // One LFSR step per pattern bit
    function automatic bpmPkg::eventTrig_t randomPattern();
        bpmPkg::eventTrig_t pattern;
        int b;
        for (b = 0; b < $bits(bpmPkg::eventTrig_t); b++) begin
            pattern[b] = lfsr[0];
            lfsr = lfsrStep(lfsr);
        end
        return pattern;
    endfunction

    ////////////////////////////////////////
    // Register access and waits
    task automatic writeReg(input bpmPkg::csrAddr_t addr, input bpmPkg::word_t data);
        @(negedge sysClk);
        csrAddr      = addr;
        csrWriteData = data;
        csrWrite     = 1'b1;
        @(negedge sysClk);
        csrWrite = 1'b0;
        // Owning register loads two edges after the write edge
        repeat (2) @(negedge sysClk);
    endtask

    task automatic readExpect(input bpmPkg::csrAddr_t addr, input bpmPkg::word_t expected);
        @(negedge sysClk);
        csrAddr = addr;
        @(negedge sysClk);
        checkWord("csrReadData", csrReadData, expected);
        if (addr == bpmPkg::interlock) begin
            checkWord("relayControl", bpmPkg::word_t'(relayControl), {31'b0, expected[0]});
        end
        if (addr == bpmPkg::spiMux) begin
            checkWord("clkSpiMuxSel", bpmPkg::word_t'(clkSpiMuxSel), {30'b0, expected[1:0]});
        end
    endtask

    task automatic waitHeartbeat(output int cycles);
        cycles = 0;
        do begin
            @(negedge sysClk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                failRun("Timed out waiting for an adcHeartbeat pulse");
            end
        end while (adcHeartbeat !== 1'b1);
    endtask

    ////////////////////////////////////////
    // Behavior checks
    task automatic checkSoftTrigger();
        bpmPkg::trigBus_t expected;
        int n;
        @(negedge sysClk);
        csrAddr  = bpmPkg::softTrigger;
        csrWrite = 1'b1;
        for (n = 1; n <= SOFT_WINDOW; n++) begin
            @(negedge sysClk);
            // Retrigger while the level is still stretched
            csrWrite = (n == 3);
            expected = (n == SOFT_LATENCY) ? bpmPkg::trigBus_t'(1) : '0;
            checkTrig("triggerStrobes", triggerStrobes, expected);
        end
    endtask

    task automatic checkEvents(input int count);
        bpmPkg::eventTrig_t oldPattern;
        bpmPkg::eventTrig_t newPattern;
        bpmPkg::trigBus_t   expected;
        int i;
        int n;
        oldPattern = eventTriggers;
        for (i = 0; i < count; i++) begin
            newPattern = randomPattern();
            @(negedge sysClk);
            eventTriggers = newPattern;
            for (n = 1; n <= EVENT_HOLD; n++) begin
                @(negedge sysClk);
                expected = (n == EVENT_LATENCY) ? {newPattern & ~oldPattern, 1'b0} : '0;
                checkTrig("triggerStrobes", triggerStrobes, expected);
            end
            oldPattern = newPattern;
        end
    endtask

    task automatic checkHeartbeat(input bpmPkg::csrAddr_t addr, input bpmPkg::word_t reload,
                                  input int expPeriod);
        int cycles;
        writeReg(addr, reload);
        // First pulse may still close an old period
        waitHeartbeat(cycles);
        waitHeartbeat(cycles);
        checkPeriod("adcHeartbeat period", cycles, expPeriod);
        waitHeartbeat(cycles);
        checkPeriod("adcHeartbeat period", cycles, expPeriod);
    endtask

    task automatic checkMarkers(input bpmPkg::csrAddr_t addr, input bpmPkg::word_t reload,
                                input bpmPkg::word_t expStatus, input logic useSa);
        string name;
        int    cycles;
        int    t;
        int    lastMark;
        name = useSa ? "saMarker" : "faMarker";
        writeReg(addr, reload);
        // Synced settles on the second heartbeat after the new reload
        waitHeartbeat(cycles);
        waitHeartbeat(cycles);
        t        = 0;
        lastMark = 0;
        do begin
            @(negedge sysClk);
            t++;
            if (t > WAIT_LIMIT) begin
                failRun("Timed out waiting for the heartbeat that ends a marker period");
            end
            if ((useSa ? saMarker : faMarker) === 1'b1) begin
                if (lastMark == 0) begin
                    checkPeriod({name, " delay"}, t, 1);
                end else begin
                    checkPeriod({name, " spacing"}, t - lastMark, int'(reload) + 1);
                end
                lastMark = t;
            end
        end while (adcHeartbeat !== 1'b1);
        // Next marker is due on or after the closing heartbeat
        if (t - lastMark > int'(reload)) begin
            failRun({name, " pulse missing before the closing heartbeat"});
        end
        readExpect(addr, expStatus);
    endtask

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int            idx;
        int            propFails;
        logic          done;
        bpmPkg::word_t cmd;
        bpmPkg::word_t data;
        bpmPkg::word_t expected;
        bpmPkg::csrAddr_t addr;

        arstN         = 1'b0;
        csrAddr       = bpmPkg::softTrigger;
        csrWrite      = 1'b0;
        csrWriteData  = '0;
        eventTriggers = '0;
        done          = 1'b0;
        $readmemh("verification/bpmTiming_testdata.txt", cmdMem);
        repeat (8) @(posedge sysClk);
        @(negedge sysClk);
        arstN = 1'b1;

        for (idx = 0; !done && idx < CMD_WORDS; idx += 4) begin
            cmd      = cmdMem[idx];
            addr     = bpmPkg::csrAddr_t'(cmdMem[idx + 1][3:0]);
            data     = cmdMem[idx + 2];
            expected = cmdMem[idx + 3];
            case (cmd)
                32'h0:   done = 1'b1;
                32'h1:   writeReg(addr, data);
                32'h2:   readExpect(addr, expected);
                32'h3:   checkSoftTrigger();
                32'h4:   checkEvents(int'(data));
                32'h5:   checkHeartbeat(addr, data, int'(expected));
                32'h6:   checkMarkers(addr, data, expected, 1'b0);
                32'h7:   checkMarkers(addr, data, expected, 1'b1);
                default: failRun("Unknown command in the test data file");
            endcase
        end
        if (!done) begin
            failRun("Test data file has no end command");
        end

        propFails = dut_i.triggerConditioner_i.trigProps_i.failCount
                  + dut_i.faDivider.markerProps_i.failCount
                  + dut_i.saDivider.markerProps_i.failCount;
        if (propFails == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            failRun("Bound assertions reported failures");
        end
    end

endmodule

/* bpmTiming.f */
+incdir+src
src/bpmPkg.sv
src/gpioRegisterBank.sv
src/triggerConditioner.sv
src/heartbeatGenerator.sv
src/markerDivider.sv
src/bpmTimingTop.sv
verification/bpmTiming_props.sv
verification/bpmTimingTb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module bpmTimingTb -f bpmTiming.f
	./obj_dir/VbpmTimingTb +verilator+error+limit+100 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/bpmTiming_testdata.txt */
// Columns cmd addr data expect in hex
// cmd 1 write  2 read  3 soft trigger  4 random events  5 heartbeat  6 FA  7 SA  0 end
1 1 F0000031 00000000
2 1 00000000 00000031
1 2 ABCD1234 00000000
2 2 00000000 00001234
1 3 FF123456 00000000
2 3 00000000 00123456
1 4 FFFFFFFF 00000000
2 4 00000000 00000001
1 5 00000006 00000000
2 5 00000000 00000002
2 0 00000000 00000000
2 7 00000000 00000000
2 F 00000000 00000000
3 0 00000000 00000000
4 0 00000020 00000000
5 1 0000001E 00000020
6 2 00000007 80000007
6 2 00000009 00000009
7 3 00000003 80000003
7 3 00000005 00000005
0 0 00000000 00000000
